/* dv/tb_dtc_sim.sv */
// testbench for the link packet generator
// sends DCS, heartbeat and data request packets, predicts every word
// from the packet rules and checks the transmit stream word by word
`timescale 1ns/1ps

module tb_dtc_sim;

   localparam int MAX_CYCLES = 3000;   // 18 packets near 30 cycles each, plus marker holds

   logic        serdes_clk = 1'b0;
   logic        serdes_resetn = 1'b0;
   logic        marker_on = 1'b0;
   logic        start = 1'b0;
   logic        cfo_emul_en = 1'b0;
   logic [3:0]  packet_type = '0;
   logic [5:0]  op_code = '0;
   logic [15:0] addr = '0;
   logic [15:0] wdata = '0;
   logic [47:0] event_window_tag = '0;
   logic [47:0] event_window_offset = '0;
   logic [31:0] event_mode = '0;
   logic [7:0]  rf_marker = '0;
   logic        on_spill = 1'b0;
   logic        datareq_last_word = 1'b0;
   logic [15:0] tx_data;
   logic [1:0]  tx_k;

   dtc_link_pkg::link_word_t exp_q [$];   // predicted words, oldest first
   logic [15:0] pay [8];                  // payload of the packet being predicted
   logic [2:0]  ring_model = '0;
   logic [47:0] tag_model = '0;
   logic        first_emul = 1'b1;
   int          word_checks = 0;
   int          value_errs = 0;
   int          other_errs = 0;
   int          cycle_cnt = 0;

   always #5 serdes_clk = ~serdes_clk;   // 10 ns

   dtc_sim_top #(.FIFO_DEPTH(32)) DUT (.*);

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic logic [15:0] crc_fold(input logic [15:0] crc_in, input logic [15:0] d);
      logic [15:0] c;
      logic        fb;
      c = crc_in;
      for (int b = 15; b >= 0; b--)   // msb first
      begin
         fb = c[15] ^ d[b];
         c  = c << 1;
         if (fb)
            c = c ^ 16'h1021;
      end
      return c;
   endfunction

   // common first two words and cleared reserved words
   task automatic base_payload(input logic [3:0] kind);
      for (int i = 2; i < 8; i++)
         pay[i] = 16'h0000;
      pay[0] = 16'h0010;          // dma count
      pay[1] = {8'h80, kind, 4'h0};
   endtask

   // header, payload and crc onto the expected queue
   task automatic push_packet(input logic [3:0] kind);
      dtc_link_pkg::link_word_t w;
      logic [15:0]              crc;
      crc    = 16'hFFFF;
      w.k    = 2'b10;
      w.data = {8'h1C, ring_model, 1'b0, kind};
      exp_q.push_back(w);
      for (int i = 0; i < 8; i++)
      begin
         w.k    = 2'b00;
         w.data = pay[i];
         crc    = crc_fold(crc, pay[i]);
         exp_q.push_back(w);
      end
      w.data = crc;
      exp_q.push_back(w);
      ring_model = ring_model + 1'b1;   // 3 bits, wraps at 8
   endtask

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////
   task automatic drain_words();
      while (exp_q.size() != 0)
      begin
         @(posedge serdes_clk);
         #1;
      end
   endtask

   // one start pulse with an optional marker hold in mid packet
   task automatic send_packet(input logic hold_marker);
      start = 1'b1;
      @(posedge serdes_clk);
      #1;
      start = 1'b0;
      if (hold_marker)
      begin
         while (exp_q.size() > 6)   // a few words already out
         begin
            @(posedge serdes_clk);
            #1;
         end
         marker_on = 1'b1;
         repeat (6) @(posedge serdes_clk);
         #1;
         marker_on = 1'b0;
      end
      drain_words();
      repeat (3) @(posedge serdes_clk);
      #1;
   endtask

   task automatic dcs_request(input logic wr);
      packet_type = 4'd0;
      op_code     = wr ? 6'd1 : 6'd0;
      addr        = 16'($urandom());
      wdata       = 16'($urandom());   // must not leak into a read
      base_payload(4'd0);
      pay[2] = {10'b0, op_code};
      pay[3] = addr;
      pay[4] = wr ? wdata : 16'h0000;
      push_packet(4'd0);
      send_packet(1'b0);
   endtask

   task automatic heartbeat_request(input logic hold_marker);
      packet_type      = 4'd1;
      event_window_tag = {16'($urandom()), $urandom()};
      event_mode       = $urandom();
      rf_marker        = 8'($urandom());
      on_spill         = ~on_spill;
      base_payload(4'd1);
      pay[2] = event_window_tag[15:0];
      pay[3] = event_window_tag[31:16];
      pay[4] = event_window_tag[47:32];
      pay[5] = event_mode[15:0];
      pay[6] = event_mode[31:16];
      pay[7] = {rf_marker, 7'b0, on_spill};
      push_packet(4'd1);
      send_packet(hold_marker);
   endtask

   task automatic data_request(input logic emul);
      cfo_emul_en      = emul;
      packet_type      = 4'd2;
      event_window_tag = {16'($urandom()), $urandom()};
      if (!emul)
         tag_model = event_window_tag;
      else if (first_emul)
      begin
         tag_model  = event_window_offset + 1'b1;
         first_emul = 1'b0;
      end
      base_payload(4'd2);
      pay[2] = tag_model[15:0];
      pay[3] = tag_model[31:16];
      pay[4] = tag_model[47:32];
      push_packet(4'd2);
      send_packet(1'b0);
   endtask

   // one rising edge on datareq_last_word moves the tag on by one
   task automatic last_word_pulse();
      datareq_last_word = 1'b1;
      repeat (2) @(posedge serdes_clk);
      #1;
      datareq_last_word = 1'b0;
      repeat (4) @(posedge serdes_clk);
      #1;
      tag_model = tag_model + 1'b1;
   endtask

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////
   idle_is_comma: assert property (@(posedge serdes_clk) disable iff (!serdes_resetn)
         tx_k == 2'b11 |-> tx_data == 16'hBC3C)
      else
      begin
         value_errs++;
         $display("Fail %0t tx_data got %h expected %h", $time, $sampled(tx_data), 16'hBC3C);
      end

   // while a marker owns the link the next cycle carries only idle
   marker_gives_idle: assert property (@(posedge serdes_clk) disable iff (!serdes_resetn)
         $past(marker_on) |-> tx_k == 2'b11)
      else
      begin
         value_errs++;
         $display("Fail %0t tx_k got %b expected %b", $time, $sampled(tx_k), 2'b11);
      end

   // every non-idle word against the head of the model queue
   always @(posedge serdes_clk)
   begin
      dtc_link_pkg::link_word_t want;
      if (serdes_resetn && tx_k != 2'b11)
      begin
         if (exp_q.size() == 0)
         begin
            other_errs++;
            $display("%0t: word %h left the DUT while no packet was expected", $time, tx_data);
         end
         else
         begin
            want = exp_q.pop_front();
            word_checks++;
            assert (tx_k == want.k)
            else
            begin
               value_errs++;
               $display("Fail %0t tx_k got %b expected %b", $time, tx_k, want.k);
            end
            assert (tx_data == want.data)
            else
            begin
               value_errs++;
               $display("Fail %0t tx_data got %h expected %h", $time, tx_data, want.data);
            end
         end
      end
   end

   // run limit
   always @(posedge serdes_clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout, run still busy after %0d cycles with %0d words outstanding",
                  MAX_CYCLES, exp_q.size());
         $display("words checked %0d, value errors %0d, other errors %0d",
                  word_checks, value_errs, other_errs);
         $display("Simulation FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////
   initial
   begin
      void'($urandom(27));
      event_window_offset = {16'($urandom()), $urandom()};
      repeat (2) @(posedge serdes_clk);
      #1;
      serdes_resetn = 1'b1;
      @(posedge serdes_clk);
      #1;
      assert (tx_k == 2'b11)
      else
      begin
         value_errs++;
         $display("Fail %0t tx_k got %b expected %b", $time, tx_k, 2'b11);
      end

      dcs_request(1'b1);
      dcs_request(1'b0);
      heartbeat_request(1'b0);
      data_request(1'b0);   // tag follows the window tag
      data_request(1'b0);
      data_request(1'b1);   // offset plus one
      last_word_pulse();
      last_word_pulse();
      data_request(1'b1);
      data_request(1'b1);   // no edge, same tag again
      heartbeat_request(1'b1);
      for (int n = 0; n < 9; n++)   // ring count wraps
         dcs_request(n[0]);

      repeat (5) @(posedge serdes_clk);
      $display("words checked %0d, value errors %0d, other errors %0d",
               word_checks, value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* hdl/dtc_crc16.sv */
// running CRC-16 over the payload words of one packet
// bitwise, msb first, one 16-bit word folded in per enabled cycle
`timescale 1ns/1ps

module dtc_crc16 (
   input  logic        serdes_clk,
   input  logic        serdes_resetn,
   input  logic        clear,    // reseed with CRC_INIT
   input  logic        enable,   // fold data in this cycle
   input  logic [15:0] data,
   output logic [15:0] crc
);

   logic [15:0] crc_next;

   // shift the word in msb first
   always_comb
   begin
      crc_next = crc;
      for (int i = 15; i >= 0; i--)
      begin
         if (crc_next[15] ^ data[i])
            crc_next = {crc_next[14:0], 1'b0} ^ dtc_link_pkg::CRC_POLY;
         else
            crc_next = {crc_next[14:0], 1'b0};
      end
   end

   always_ff @(posedge serdes_clk or negedge serdes_resetn)
   begin
      if (!serdes_resetn)
         crc <= dtc_link_pkg::CRC_INIT;
      else if (clear)
         crc <= dtc_link_pkg::CRC_INIT;
      else if (enable)
         crc <= crc_next;
   end

endmodule

/* hdl/dtc_link_pkg.sv */
// link layer symbols for the timing and control link
// k flags, idle comma, packet geometry, CRC constants and the
// word type passed from the packet builder to the transmit buffer
package dtc_link_pkg;

   // one transceiver word with its k-char flags
   typedef struct packed {
      logic [1:0]  k;      // 11 idle, 10 command, 00 data
      logic [15:0] data;
   } link_word_t;

   // k flag encodings
   localparam logic [1:0] K_IDLE = 2'b11;   // both bytes are k-chars
   localparam logic [1:0] K_CMD  = 2'b10;   // upper byte k28.0, lower byte data
   localparam logic [1:0] K_DATA = 2'b00;   // plain data word

   localparam logic [15:0] COMMA = 16'hBC3C;   // k28.5 k28.1 idle pair

   // header + payload + crc
   localparam int PKT_WORDS     = 10;
   localparam int PAYLOAD_WORDS = 8;

   // ccitt polynomial, all-ones seed
   localparam logic [15:0] CRC_POLY = 16'h1021;
   localparam logic [15:0] CRC_INIT = 16'hFFFF;

endpackage

/* hdl/dtc_packet_builder.sv */
// packet builder
// turns one captured request into header, eight payload words and
// a CRC word, written to the transmit buffer on consecutive cycles
// header carries the kind and a rolling 3-bit ring count
`timescale 1ns/1ps

module dtc_packet_builder (
   input  logic                    serdes_clk,
   input  logic                    serdes_resetn,
   dtc_req_if.dst                  req,
   input  logic                    room,      // buffer can take a whole packet
   output logic                    wr_en,     // one pulse per word
   output dtc_link_pkg::link_word_t wr_word
);

   localparam int IW = $clog2(dtc_link_pkg::PAYLOAD_WORDS);

   typedef enum logic [1:0] {
      ST_IDLE,   // wait for a start
      ST_PAY,    // payload words
      ST_CRC,    // crc word
      ST_GAP     // one dead cycle after the packet
   } state_t;

   state_t                 state;
   logic [IW-1:0]          idx;        // payload word index
   dtc_req_pkg::ring_cnt_t ring_cnt;
   logic [15:0]            pay_word;   // payload word at idx
   logic [15:0]            crc;
   logic                   crc_clr, crc_en;

   assign crc_clr = (state == ST_IDLE);   // reseed between packets
   assign crc_en  = (state == ST_PAY);    // fold in each payload word as written

   ////////////////////////////////////////
   // payload word select
   ////////////////////////////////////////
   always_comb
   begin
      pay_word = 16'h0000;   // reserved words default to zero
      if (idx == 0)
         pay_word = dtc_req_pkg::DMA_COUNT;
      else if (idx == 1)
         pay_word = {dtc_req_pkg::VALID_BIT, req.kind, 4'h0};  // roc link and hop count zero
      else
      begin
         case (req.kind)
            dtc_req_pkg::DCS_REQ:
               case (idx)
                  2: pay_word = {10'b0, req.op_code};
                  3: pay_word = req.addr;
                  4: if (req.op_code == dtc_req_pkg::OP_SINGLE_WR)
                        pay_word = req.wdata;   // read carries zero here
                  default: pay_word = 16'h0000;
               endcase
            dtc_req_pkg::HEARTBEAT:
               case (idx)
                  2: pay_word = req.window_tag[15:0];
                  3: pay_word = req.window_tag[31:16];
                  4: pay_word = req.window_tag[47:32];
                  5: pay_word = req.event_mode[15:0];
                  6: pay_word = req.event_mode[31:16];
                  default: pay_word = {req.rf_marker, 7'b0, req.on_spill};
               endcase
            dtc_req_pkg::DATA_REQ:
               case (idx)
                  2: pay_word = req.event_tag[15:0];
                  3: pay_word = req.event_tag[31:16];
                  4: pay_word = req.event_tag[47:32];
                  default: pay_word = 16'h0000;   // three reserved words
               endcase
            default: pay_word = 16'h0000;
         endcase
      end
   end

   ////////////////////////////////////////
   // word sequencer
   ////////////////////////////////////////
   always_ff @(posedge serdes_clk or negedge serdes_resetn)
   begin
      if (!serdes_resetn)
      begin
         state    <= ST_IDLE;
         idx      <= '0;
         ring_cnt <= '0;
         wr_en    <= 1'b0;
      end
      else
      begin
         wr_en <= 1'b0;
         case (state)
            ST_IDLE:
               if (req.req_start && room)   // start lost if no room
               begin
                  wr_en    <= 1'b1;
                  ring_cnt <= ring_cnt + 1'b1;   // wraps at 8
                  idx      <= '0;
                  state    <= ST_PAY;
               end
            ST_PAY:
            begin
               wr_en <= 1'b1;
               idx   <= idx + 1'b1;
               if (idx == IW'(dtc_link_pkg::PAYLOAD_WORDS - 1))
                  state <= ST_CRC;
            end
            ST_CRC:
            begin
               wr_en <= 1'b1;   // crc already holds all eight words
               state <= ST_GAP;
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // word data written along with wr_en
   always_ff @(posedge serdes_clk)
   begin
      case (state)
         ST_IDLE: wr_word <= {dtc_link_pkg::K_CMD, dtc_req_pkg::HDR_K_BASE,
                              ring_cnt, 1'b0, req.kind};
         ST_PAY:  wr_word <= {dtc_link_pkg::K_DATA, pay_word};
         ST_CRC:  wr_word <= {dtc_link_pkg::K_DATA, crc};
         default: wr_word <= wr_word;
      endcase
   end

   dtc_crc16 u_crc (
      .serdes_clk    (serdes_clk),
      .serdes_resetn (serdes_resetn),
      .clear         (crc_clr),
      .enable        (crc_en),
      .data          (pay_word),
      .crc           (crc)
   );

endmodule

/* hdl/dtc_req_if.sv */
// captured request bus
// carries one request from the capture stage to the packet builder,
// req_start pulses for one cycle and the fields hold until the next start
`timescale 1ns/1ps

interface dtc_req_if;

   logic                   req_start;   // single cycle, no handshake
   dtc_req_pkg::pkt_kind_t kind;
   dtc_req_pkg::op_t       op_code;
   logic [15:0]            addr;
   logic [15:0]            wdata;
   dtc_req_pkg::tag_t      window_tag;  // heartbeat tag
   logic [31:0]            event_mode;
   logic [7:0]             rf_marker;
   logic                   on_spill;
   dtc_req_pkg::tag_t      event_tag;   // data request tag

   // capture side drives everything
   modport src (
      output req_start, kind, op_code, addr, wdata, window_tag,
             event_mode, rf_marker, on_spill, event_tag
   );

   // builder side only reads
   modport dst (
      input  req_start, kind, op_code, addr, wdata, window_tag,
             event_mode, rf_marker, on_spill, event_tag
   );

endinterface

/* hdl/dtc_req_pkg.sv */
// request level definitions for the link packet generator
// packet kinds, DCS operation codes, field widths and the
// types carried by a captured request
package dtc_req_pkg;

   // kinds this generator originates, value goes into header bits 3:0
   typedef enum logic [3:0] {
      DCS_REQ   = 4'd0,
      HEARTBEAT = 4'd1,
      DATA_REQ  = 4'd2
   } pkt_kind_t;

   // DCS operation code, bit 5 reserved
   localparam int OP_W = 6;
   typedef logic [OP_W-1:0] op_t;
   localparam op_t OP_SINGLE_RD = 6'd0;
   localparam op_t OP_SINGLE_WR = 6'd1;

   // event window / event tag
   localparam int TAG_W = 48;
   typedef logic [TAG_W-1:0] tag_t;

   localparam logic [7:0]  HDR_K_BASE = 8'h1C;    // k28.0 in the header upper byte
   localparam logic [15:0] DMA_COUNT  = 16'h0010; // fixed dma byte count
   localparam logic [7:0]  VALID_BIT  = 8'h80;    // valid flag, upper byte of word 1

   typedef logic [2:0] ring_cnt_t;   // header bits 7:5

endpackage

/* hdl/dtc_request_capture.sv */
// request capture
// registers the request inputs and issues a one-cycle start to the
// builder, also keeps the event tag used by data request packets
`timescale 1ns/1ps

module dtc_request_capture (
   input  logic              serdes_clk,
   input  logic              serdes_resetn,
   input  logic              start,
   input  logic              cfo_emul_en,           // tag counts locally when set
   input  logic [3:0]        packet_type,
   input  dtc_req_pkg::op_t  op_code,
   input  logic [15:0]       addr,
   input  logic [15:0]       wdata,
   input  dtc_req_pkg::tag_t event_window_tag,
   input  dtc_req_pkg::tag_t event_window_offset,   // base for the first emulated tag
   input  logic [31:0]       event_mode,
   input  logic [7:0]        rf_marker,
   input  logic              on_spill,
   input  logic              datareq_last_word,     // previous data request done
   dtc_req_if.src            req
);

   logic              last_d1, last_d2;   // two stage sample of datareq_last_word
   logic              last_rise;
   logic              first_start;        // no emulated start seen since reset
   dtc_req_pkg::tag_t evt_tag;
   dtc_req_pkg::tag_t evt_tag_next;

   assign last_rise = last_d1 & ~last_d2;

   // tag update, a start overrides the edge increment
   always_comb
   begin
      evt_tag_next = evt_tag;
      if (last_rise)
         evt_tag_next = evt_tag + 1'b1;   // assume tags step by one per request
      if (start)
      begin
         if (!cfo_emul_en)
            evt_tag_next = event_window_tag;
         else if (first_start)
            evt_tag_next = event_window_offset + 1'b1;
      end
   end

   always_ff @(posedge serdes_clk or negedge serdes_resetn)
   begin
      if (!serdes_resetn)
      begin
         req.req_start <= 1'b0;
         last_d1       <= 1'b0;
         last_d2       <= 1'b0;
         first_start   <= 1'b1;
         evt_tag       <= '0;
      end
      else
      begin
         req.req_start <= start;   // builder sees it one cycle later
         last_d1       <= datareq_last_word;
         last_d2       <= last_d1;
         evt_tag       <= evt_tag_next;
         if (start && cfo_emul_en)
            first_start <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // request fields, loaded on start
   ////////////////////////////////////////
   always_ff @(posedge serdes_clk)
   begin
      if (start)
      begin
         req.kind       <= dtc_req_pkg::pkt_kind_t'(packet_type);
         req.op_code    <= op_code;
         req.addr       <= addr;
         req.wdata      <= wdata;
         req.window_tag <= event_window_tag;
         req.event_mode <= event_mode;
         req.rf_marker  <= rf_marker;
         req.on_spill   <= on_spill;
         req.event_tag  <= evt_tag_next;   // snapshot, later edges do not disturb it
      end
   end

endmodule

/* hdl/dtc_sim_top.sv */
// link packet generator top level
// request capture -> packet builder -> buffered transmit, all on
// the serdes clock; plain ports toward the test environment
`timescale 1ns/1ps

module dtc_sim_top #(
   parameter int FIFO_DEPTH = 32   // packet buffer words
) (
   input  logic                       serdes_clk,
   input  logic                       serdes_resetn,
   input  logic                       marker_on,
   input  logic                       start,
   input  logic                       cfo_emul_en,
   input  logic [3:0]                 packet_type,   // 0 dcs, 1 heartbeat, 2 data request
   input  logic [5:0]                 op_code,       // 0 single read, 1 single write
   input  logic [15:0]                addr,
   input  logic [15:0]                wdata,
   input  logic [dtc_req_pkg::TAG_W-1:0] event_window_tag,
   input  logic [dtc_req_pkg::TAG_W-1:0] event_window_offset,
   input  logic [31:0]                event_mode,
   input  logic [7:0]                 rf_marker,
   input  logic                       on_spill,
   input  logic                       datareq_last_word,
   output logic [15:0]                tx_data,
   output logic [1:0]                 tx_k
);

   dtc_req_if                req_bus ();
   logic                     wr_en;
   dtc_link_pkg::link_word_t wr_word;
   logic                     room;

   dtc_request_capture u_capture (
      .serdes_clk          (serdes_clk),
      .serdes_resetn       (serdes_resetn),
      .start               (start),
      .cfo_emul_en         (cfo_emul_en),
      .packet_type         (packet_type),
      .op_code             (op_code),
      .addr                (addr),
      .wdata               (wdata),
      .event_window_tag    (event_window_tag),
      .event_window_offset (event_window_offset),
      .event_mode          (event_mode),
      .rf_marker           (rf_marker),
      .on_spill            (on_spill),
      .datareq_last_word   (datareq_last_word),
      .req                 (req_bus.src)
   );

   dtc_packet_builder u_builder (
      .serdes_clk    (serdes_clk),
      .serdes_resetn (serdes_resetn),
      .req           (req_bus.dst),
      .room          (room),
      .wr_en         (wr_en),
      .wr_word       (wr_word)
   );

   dtc_tx_sender #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_sender (
      .serdes_clk    (serdes_clk),
      .serdes_resetn (serdes_resetn),
      .wr_en         (wr_en),
      .wr_word       (wr_word),
      .marker_on     (marker_on),
      .room          (room),
      .tx_data       (tx_data),
      .tx_k          (tx_k)
   );

endmodule

/* hdl/dtc_tx_sender.sv */
// transmit stage
// packet buffer between builder and transceiver; a packet is read out
// only once all of its words are in, reads hold off while markers
// own the link, idle commas fill every other cycle
`timescale 1ns/1ps

module dtc_tx_sender #(
   parameter int FIFO_DEPTH = 32
) (
   input  logic                     serdes_clk,
   input  logic                     serdes_resetn,
   input  logic                     wr_en,
   input  dtc_link_pkg::link_word_t wr_word,
   input  logic                     marker_on,   // markers take priority on the fiber
   output logic                     room,        // space for one more packet
   output logic [15:0]              tx_data,
   output logic [1:0]               tx_k
);

   localparam int AW = $clog2(FIFO_DEPTH);
   localparam int CW = $clog2(FIFO_DEPTH + 1);
   localparam int BW = $clog2(dtc_link_pkg::PKT_WORDS);

   dtc_link_pkg::link_word_t mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr, rd_ptr;
   logic [CW-1:0] fill;        // words held
   logic          burst;       // packet readout in progress
   logic [BW-1:0] burst_cnt;   // words read in this burst
   logic          rd_en;

   assign room  = (fill <= CW'(FIFO_DEPTH - dtc_link_pkg::PKT_WORDS));
   assign rd_en = burst & ~marker_on;   // pause mid packet, resume in place

   always_ff @(posedge serdes_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_word;
   end

   ////////////////////////////////////////
   // pointers, fill and burst control
   ////////////////////////////////////////
   always_ff @(posedge serdes_clk or negedge serdes_resetn)
   begin
      if (!serdes_resetn)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         burst     <= 1'b0;
         burst_cnt <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         fill <= fill + CW'(wr_en) - CW'(rd_en);

         if (!burst && fill >= CW'(dtc_link_pkg::PKT_WORDS))
            burst <= 1'b1;   // a whole packet is waiting
         else if (rd_en)
         begin
            burst_cnt <= burst_cnt + 1'b1;
            if (burst_cnt == BW'(dtc_link_pkg::PKT_WORDS - 1))
            begin
               burst     <= 1'b0;   // last word of the packet
               burst_cnt <= '0;
            end
         end
      end
   end

   // output register, comma whenever nothing was read
   always_ff @(posedge serdes_clk or negedge serdes_resetn)
   begin
      if (!serdes_resetn)
      begin
         tx_data <= dtc_link_pkg::COMMA;
         tx_k    <= dtc_link_pkg::K_IDLE;
      end
      else if (rd_en)
      begin
         tx_data <= mem[rd_ptr].data;
         tx_k    <= mem[rd_ptr].k;
      end
      else
      begin
         tx_data <= dtc_link_pkg::COMMA;
         tx_k    <= dtc_link_pkg::K_IDLE;
      end
   end

endmodule

/* verilog.f */
hdl/dtc_link_pkg.sv
hdl/dtc_req_pkg.sv
hdl/dtc_req_if.sv
hdl/dtc_crc16.sv
hdl/dtc_request_capture.sv
hdl/dtc_packet_builder.sv
hdl/dtc_tx_sender.sv
hdl/dtc_sim_top.sv
dv/tb_dtc_sim.sv
